//--- list.f
src/cpuPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/fetchUnit.sv
src/memAccessUnit.sv
src/memArbiter.sv
src/datapath.sv
src/cpu.sv
testbench/cpuSva_sva.sv
testbench/tbCpu.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tbCpu -Mdir obj_dir -f list.f; then
	echo "Build failed"
	exit 1
fi

if ! ./obj_dir/VtbCpu > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
exit 0

//--- testbench/tbCpu.sv
module tbCpu;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int TIMEOUT_CYCLES = 1000; // ~40 instructions at 12 cycles, plus margin
	localparam int NUM_STORES = 18;
	localparam word_t A = 16'd5;
	localparam word_t B = 16'hFFFD;
	localparam word_t DATA0 = 16'h1234;
	localparam word_t DATA1 = 16'hBEEF;

	logic clk = 1'b0;
	logic reset;
	word_t readData;
	logic inputReady;
	logic ackOutput;
	logic readM;
	logic writeM;
	word_t address;
	word_t writeData;
	logic halted;

	word_t mem [256];
	word_t expAddr [NUM_STORES];
	word_t expData [NUM_STORES];
	int seed = 32'h54472cc5;
	int storeCount = 0;
	int cycles = 0;
	int progPtr = 0;
	int waitCnt = 0;
	logic busy = 1'b0;
	logic verdictShown = 1'b0;

	cpu #(
		.RESET_ADDRESS(16'h0000)
	) i_dut (.*);

	bind cpu cpuSva i_cpuSva (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	function automatic word_t encodeR(func_t f, regAddr_t rs, regAddr_t rt, regAddr_t rd);
		return {OP_RTYPE, rs, rt, rd, f};
	endfunction

	function automatic word_t encodeI(opcode_t op, regAddr_t rs, regAddr_t rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encodeJ(opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic emit(word_t w);
		mem[progPtr] = w;
		progPtr++;
	endtask

	task automatic expectStore(int idx, word_t addr, word_t value);
		expAddr[idx] = addr;
		expData[idx] = value;
	endtask

	task automatic loadProgram();
		word_t wrongPath;
		wrongPath = encodeI(OP_SWD, 0, 1, 8'h6F); // Never reached when flow is right
		for (int i = 0; i < 256; i++) begin
			mem[i] = word_t'(16'hC000 + i);
		end
		mem[8'h70] = DATA0;
		mem[8'h71] = DATA1;
		emit(encodeI(OP_ADI, 0, 1, 8'd5)); // 0: r1 = 5
		emit(encodeI(OP_ADI, 0, 2, 8'hFD)); // r2 = -3
		emit(encodeR(FUNC_ADD, 1, 2, 3));
		emit(encodeI(OP_SWD, 0, 3, 8'h50));
		emit(encodeR(FUNC_SUB, 1, 2, 3)); // 4
		emit(encodeI(OP_SWD, 0, 3, 8'h51));
		emit(encodeR(FUNC_AND, 1, 2, 3));
		emit(encodeI(OP_SWD, 0, 3, 8'h52));
		emit(encodeR(FUNC_ORR, 1, 2, 3)); // 8
		emit(encodeI(OP_SWD, 0, 3, 8'h53));
		emit(encodeR(FUNC_NOT, 1, 0, 3));
		emit(encodeI(OP_SWD, 0, 3, 8'h54));
		emit(encodeR(FUNC_TCP, 2, 0, 3)); // 12
		emit(encodeI(OP_SWD, 0, 3, 8'h55));
		emit(encodeR(FUNC_SHL, 1, 0, 3));
		emit(encodeI(OP_SWD, 0, 3, 8'h56));
		emit(encodeR(FUNC_SHR, 2, 0, 3)); // 16
		emit(encodeI(OP_SWD, 0, 3, 8'h57));
		emit(encodeI(OP_ORI, 1, 3, 8'hF0));
		emit(encodeI(OP_SWD, 0, 3, 8'h58));
		emit(encodeI(OP_LHI, 0, 3, 8'h12)); // 20
		emit(encodeI(OP_SWD, 0, 3, 8'h59));
		emit(encodeI(OP_LWD, 0, 3, 8'h70));
		emit(encodeI(OP_SWD, 0, 3, 8'h5A));
		emit(encodeR(FUNC_ADD, 3, 1, 3)); // 24: uses the loaded word
		emit(encodeI(OP_SWD, 0, 3, 8'h5B));
		emit(encodeI(OP_BNE, 1, 2, 8'd1)); // 26: taken
		emit(wrongPath);
		emit(encodeI(OP_BEQ, 1, 2, 8'd1)); // 28: not taken
		emit(encodeI(OP_SWD, 0, 1, 8'h5C));
		emit(encodeI(OP_BGZ, 1, 0, 8'd1)); // 30: taken
		emit(wrongPath);
		emit(encodeI(OP_BLZ, 1, 0, 8'd1)); // 32: not taken
		emit(encodeI(OP_SWD, 0, 2, 8'h5D));
		emit(encodeI(OP_BLZ, 2, 0, 8'd1)); // 34: taken
		emit(wrongPath);
		emit(encodeI(OP_BGZ, 2, 0, 8'd1)); // 36: not taken
		emit(encodeJ(OP_JAL, 12'd40)); // 37: r2 = 38
		emit(wrongPath);
		emit(wrongPath);
		emit(encodeI(OP_SWD, 0, 2, 8'h5E)); // 40
		emit(encodeI(OP_ADI, 0, 3, 8'd46));
		emit(encodeR(FUNC_JRL, 3, 0, 0)); // 42: r2 = 43
		emit(wrongPath);
		emit(wrongPath);
		emit(wrongPath);
		emit(encodeI(OP_SWD, 0, 2, 8'h5F)); // 46
		emit(encodeI(OP_ADI, 0, 3, 8'd51));
		emit(encodeR(FUNC_JPR, 3, 0, 0)); // 48
		emit(wrongPath);
		emit(wrongPath);
		emit(encodeJ(OP_JMP, 12'd53)); // 51
		emit(wrongPath);
		emit(encodeI(OP_SWD, 0, 3, 8'h60)); // 53
		emit(encodeI(OP_LWD, 0, 3, 8'h71)); // 54: second data word
		emit(encodeI(OP_SWD, 0, 3, 8'h61));
		emit(encodeR(FUNC_HLT, 0, 0, 0));
	endtask

	task automatic buildExpected();
		expectStore(0, 16'h50, A + B);
		expectStore(1, 16'h51, A - B);
		expectStore(2, 16'h52, A & B);
		expectStore(3, 16'h53, A | B);
		expectStore(4, 16'h54, ~A);
		expectStore(5, 16'h55, 16'd0 - B);
		expectStore(6, 16'h56, A << 1);
		expectStore(7, 16'h57, word_t'($signed(B) >>> 1));
		expectStore(8, 16'h58, A | 16'h00F0);
		expectStore(9, 16'h59, 16'h1200);
		expectStore(10, 16'h5A, DATA0);
		expectStore(11, 16'h5B, DATA0 + A);
		expectStore(12, 16'h5C, A);
		expectStore(13, 16'h5D, B);
		expectStore(14, 16'h5E, 16'd37 + 16'd1); // JAL at 37
		expectStore(15, 16'h5F, 16'd42 + 16'd1); // JRL at 42
		expectStore(16, 16'h60, 16'd51);
		expectStore(17, 16'h61, DATA1);
	endtask

	function automatic logic storeMatches(int idx, word_t addr, word_t value);
		if (idx >= NUM_STORES) begin
			return 1'b0;
		end
		return (addr == expAddr[idx]) && (value == expData[idx]);
	endfunction

	// Memory model with 1 to 4 cycles of latency
	always @(posedge clk) begin
		#1;
		inputReady = 1'b0;
		ackOutput = 1'b0;
		if (reset) begin
			busy = 1'b0;
			waitCnt = 0;
		end else if (busy) begin
			if (waitCnt > 0) begin
				waitCnt--;
			end else begin
				busy = 1'b0;
				if (readM) begin
					readData = mem[address[7:0]];
					inputReady = 1'b1;
				end else begin
					storeCheck: assert (storeMatches(storeCount, address, writeData))
					else begin
						verdictShown = 1'b1;
						$display("ERROR at %0t: store %0d wrote %h to %h", $time,
							storeCount, writeData, address);
						$display("CHECKS FAILED");
						$fatal(1, "Wrong store");
					end
					mem[address[7:0]] = writeData;
					storeCount++;
					ackOutput = 1'b1;
				end
			end
		end else if (readM || writeM) begin
			busy = 1'b1;
			waitCnt = $unsigned($random(seed)) % 4;
		end
	end

	initial begin
		reset = 1'b1;
		readData = '0;
		inputReady = 1'b0;
		ackOutput = 1'b0;
		loadProgram();
		buildExpected();
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		while (!halted && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		repeat (10) @(posedge clk); // Let the halt assertions watch the bus
		verdictShown = 1'b1;
		if (!halted) begin
			$display("Timeout: processor did not halt within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "Timeout");
		end else if (storeCount != NUM_STORES) begin
			$display("Halted after %0d of %0d expected stores", storeCount, NUM_STORES);
			$display("CHECKS FAILED");
			$fatal(1, "Missing stores");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

	final begin
		if (!verdictShown) begin
			$display("CHECKS FAILED");
		end
	end
endmodule

//--- testbench/cpuSva_sva.sv
module cpuSva (
	input logic clk,
	input logic reset,
	input logic readM,
	input logic writeM,
	input cpuPkg::word_t address,
	input cpuPkg::word_t writeData,
	input logic inputReady,
	input logic ackOutput,
	input logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	logic response;

	assign response = inputReady || ackOutput;

	// One request kind at a time
	noOverlap: assert property (@(posedge clk) disable iff (reset)
		!(readM && writeM))
		else $error("readM and writeM high together");

	// A pending request keeps its kind, address and data until answered
	stableRequest: assert property (@(posedge clk) disable iff (reset)
		((readM || writeM) && !response) |=>
			($stable(readM) && $stable(writeM)
			&& $stable(address) && $stable(writeData)))
		else $error("request dropped or changed before its response");

	haltSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("halted dropped");

	// Only a fetch already granted may finish after the halt
	noRequestAfterHalt: assert property (@(posedge clk) disable iff (reset)
		halted |-> !$rose(readM) && !$rose(writeM))
		else $error("new memory request after halt");
endmodule

//--- src/cpu.sv
module cpu #(
	parameter cpuPkg::word_t RESET_ADDRESS = '0
) (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t readData,
	input logic inputReady,
	input logic ackOutput,
	output logic readM,
	output logic writeM,
	output cpuPkg::word_t address,
	output cpuPkg::word_t writeData,
	output logic halted
);
	import cpuPkg::*;

	// Arbiter side
	logic fetchReq, fetchDone, dataReq, dataWrite, dataDone;
	word_t fetchAddr, dataAddr, dataWData, respData;

	// Fetch buffer and redirect
	logic take, redirect, instValid;
	word_t redirectPc, instWord, instPc, instruction;

	// Decoded controls
	logic jump, branch, memToReg, memRead, memWrite;
	logic regDst, regWrite, aluSrc, link, halt;
	aluOp_t aluOp;

	// Register file, ALU and load path
	regAddr_t readAddr1, readAddr2, writeAddr;
	logic writeEnable, isZero, isNegative, isEqual, memStart, memDone;
	word_t writeValue, readValue1, readValue2, operandA, operandB, aluResult, loadValue;

	memArbiter i_memArbiter (.*);

	fetchUnit #(
		.RESET_ADDRESS(RESET_ADDRESS)
	) i_fetchUnit (
		.fetchData(respData),
		.*
	);

	memAccessUnit i_memAccessUnit (
		.start(memStart),
		.write(memWrite),
		.addr(aluResult),
		.storeValue(readValue2),
		.dataIn(respData),
		.done(memDone),
		.*
	);

	datapath i_datapath (.*);

	controlUnit i_controlUnit (.*);

	registerFile i_registerFile (.*);

	alu i_alu (
		.result(aluResult),
		.*
	);
endmodule

//--- src/datapath.sv
module datapath (
	input logic clk,
	input logic reset,
	input logic jump,
	input logic branch,
	input logic memToReg,
	input logic memRead,
	input logic memWrite,
	input logic regDst,
	input logic regWrite,
	input logic aluSrc,
	input logic link,
	input logic halt,
	input logic instValid,
	input cpuPkg::word_t instWord,
	input cpuPkg::word_t instPc,
	input cpuPkg::word_t aluResult,
	input logic isZero,
	input logic isNegative,
	input logic isEqual,
	input cpuPkg::word_t readValue1,
	input cpuPkg::word_t readValue2,
	input logic memDone,
	input cpuPkg::word_t loadValue,
	output logic take,
	output logic redirect,
	output cpuPkg::word_t redirectPc,
	output cpuPkg::regAddr_t readAddr1,
	output cpuPkg::regAddr_t readAddr2,
	output cpuPkg::regAddr_t writeAddr,
	output logic writeEnable,
	output cpuPkg::word_t writeValue,
	output cpuPkg::word_t operandA,
	output cpuPkg::word_t operandB,
	output logic memStart,
	output cpuPkg::word_t instruction,
	output logic halted
);
	import cpuPkg::*;

	cpuState_t state;
	cpuState_t nextState;
	word_t pc; // Address of the instruction being executed
	word_t pcPlus1;
	word_t immExt;
	word_t jumpTarget;
	opcode_t opcode;
	logic condMet;

	assign opcode = instruction[15:12];
	assign pcPlus1 = pc + 16'd1;
	// Sign-extended except for ORI
	assign immExt = (opcode == OP_ORI) ? {8'h00, instruction[7:0]}
		: {{8{instruction[7]}}, instruction[7:0]};
	assign jumpTarget = aluSrc ? {pcPlus1[15:12], instruction[11:0]} : readValue1;

	always_comb begin
		case (opcode)
			OP_BNE: condMet = !isEqual;
			OP_BEQ: condMet = isEqual;
			OP_BGZ: condMet = !isZero && !isNegative;
			default: condMet = isNegative; // BLZ
		endcase
	end

	assign take = (state == FETCH) && instValid;
	assign redirect = (state == EXECUTE) && (jump || (branch && condMet));
	assign redirectPc = jump ? jumpTarget : pcPlus1 + immExt;
	assign memStart = (state == EXECUTE) && (memRead || memWrite);
	assign halted = (state == HALTED);

	assign readAddr1 = instruction[11:10]; // rs
	assign readAddr2 = instruction[9:8]; // rt
	assign operandA = readValue1;
	assign operandB = aluSrc ? immExt : readValue2;

	always_comb begin
		if (link) begin
			writeAddr = regAddr_t'(2);
		end else if (regDst) begin
			writeAddr = instruction[7:6];
		end else begin
			writeAddr = instruction[9:8];
		end
		if (link) begin
			writeValue = pcPlus1;
		end else if (memToReg) begin
			writeValue = loadValue;
		end else if (opcode == OP_LHI) begin
			writeValue = {instruction[7:0], 8'h00};
		end else begin
			writeValue = aluResult;
		end
	end

	// Loads write back from MEMORY, everything else from EXECUTE
	assign writeEnable = ((state == EXECUTE) && regWrite && !memRead)
		|| ((state == MEMORY) && memRead && memDone);

	always_comb begin
		nextState = state;
		case (state)
			FETCH: if (instValid) nextState = EXECUTE;
			EXECUTE: begin
				if (halt) begin
					nextState = HALTED;
				end else if (memRead || memWrite) begin
					nextState = MEMORY;
				end else begin
					nextState = FETCH;
				end
			end
			MEMORY: if (memDone) nextState = FETCH;
			default: nextState = HALTED;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			instruction <= instWord;
			pc <= instPc;
		end
	end
endmodule

//--- src/memArbiter.sv
module memArbiter (
	input logic clk,
	input logic reset,
	input logic fetchReq,
	input cpuPkg::word_t fetchAddr,
	input logic dataReq,
	input logic dataWrite,
	input cpuPkg::word_t dataAddr,
	input cpuPkg::word_t dataWData,
	input cpuPkg::word_t readData,
	input logic inputReady,
	input logic ackOutput,
	output logic readM,
	output logic writeM,
	output cpuPkg::word_t address,
	output cpuPkg::word_t writeData,
	output logic fetchDone,
	output logic dataDone,
	output cpuPkg::word_t respData
);
	logic ownerIsData;
	logic response;

	assign response = (readM && inputReady) || (writeM && ackOutput);
	assign dataDone = response && ownerIsData;
	assign fetchDone = response && !ownerIsData;
	assign respData = readData;

	// Bus is idle for one cycle after each response
	always_ff @(posedge clk) begin
		if (reset) begin
			readM <= 1'b0;
			writeM <= 1'b0;
			ownerIsData <= 1'b0;
		end else if (readM || writeM) begin
			if (response) begin
				readM <= 1'b0;
				writeM <= 1'b0;
			end
		end else if (dataReq) begin
			ownerIsData <= 1'b1; // Data side wins a tie
			readM <= !dataWrite;
			writeM <= dataWrite;
		end else if (fetchReq) begin
			ownerIsData <= 1'b0;
			readM <= 1'b1;
		end
	end

	// Address and data latched at grant, held for the whole request
	always_ff @(posedge clk) begin
		if (!readM && !writeM) begin
			address <= dataReq ? dataAddr : fetchAddr;
			writeData <= dataWData;
		end
	end
endmodule

//--- src/memAccessUnit.sv
module memAccessUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input logic write,
	input cpuPkg::word_t addr,
	input cpuPkg::word_t storeValue,
	input logic dataDone,
	input cpuPkg::word_t dataIn,
	output logic dataReq,
	output logic dataWrite,
	output cpuPkg::word_t dataAddr,
	output cpuPkg::word_t dataWData,
	output cpuPkg::word_t loadValue,
	output logic done
);
	always_ff @(posedge clk) begin
		if (reset) begin
			dataReq <= 1'b0;
			dataWrite <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= dataDone; // One cycle later, with loadValue settled
			if (start) begin
				dataReq <= 1'b1;
				dataWrite <= write;
			end else if (dataDone) begin
				dataReq <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dataAddr <= addr;
			dataWData <= storeValue;
		end
		if (dataDone && !dataWrite) begin
			loadValue <= dataIn;
		end
	end
endmodule

//--- src/fetchUnit.sv
module fetchUnit #(
	parameter cpuPkg::word_t RESET_ADDRESS = '0
) (
	input logic clk,
	input logic reset,
	input logic take,
	input logic redirect,
	input cpuPkg::word_t redirectPc,
	input logic fetchDone,
	input cpuPkg::word_t fetchData,
	output logic fetchReq,
	output cpuPkg::word_t fetchAddr,
	output logic instValid,
	output cpuPkg::word_t instWord,
	output cpuPkg::word_t instPc
);
	logic running; // Low only while in reset
	logic stale; // Fetch in flight belongs to a flushed path

	// Fetch ahead when the buffer is empty or being consumed
	assign fetchReq = running && (!instValid || take);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			stale <= 1'b0;
			instValid <= 1'b0;
			fetchAddr <= RESET_ADDRESS;
		end else begin
			running <= 1'b1;
			if (redirect) begin
				fetchAddr <= redirectPc;
				instValid <= 1'b0;
				stale <= fetchReq && !fetchDone;
			end else if (fetchDone) begin
				if (stale) begin
					stale <= 1'b0; // Word from the old path is dropped
				end else begin
					instValid <= 1'b1;
					fetchAddr <= fetchAddr + 16'd1;
				end
			end else if (take) begin
				instValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetchDone && !stale && !redirect) begin
			instWord <= fetchData;
			instPc <= fetchAddr;
		end
	end
endmodule

//--- src/alu.sv
module alu (
	input cpuPkg::word_t operandA,
	input cpuPkg::word_t operandB,
	input cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t result,
	output logic isZero,
	output logic isNegative,
	output logic isEqual
);
	import cpuPkg::*;

	always_comb begin
		case (aluOp)
			ALU_ADD: result = operandA + operandB;
			ALU_SUB: result = operandA - operandB;
			ALU_AND: result = operandA & operandB;
			ALU_OR: result = operandA | operandB;
			ALU_NOT: result = ~operandA;
			ALU_TCP: result = ~operandA + 16'd1;
			ALU_ALS: result = {operandA[WORD_SIZE-2:0], 1'b0};
			ALU_ARS: result = {operandA[WORD_SIZE-1], operandA[WORD_SIZE-1:1]}; // Keeps sign
			default: result = '0;
		endcase
	end

	// Branch flags describe rs, or rs against rt
	assign isZero = (operandA == '0);
	assign isNegative = operandA[WORD_SIZE-1];
	assign isEqual = (operandA == operandB);
endmodule

//--- src/registerFile.sv
module registerFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regAddr_t readAddr1,
	input cpuPkg::regAddr_t readAddr2,
	input cpuPkg::regAddr_t writeAddr,
	input logic writeEnable,
	input cpuPkg::word_t writeValue,
	output cpuPkg::word_t readValue1,
	output cpuPkg::word_t readValue2
);
	import cpuPkg::*;

	word_t regs [4];

	// Reads see the old value during a write
	assign readValue1 = regs[readAddr1];
	assign readValue2 = regs[readAddr2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeValue;
		end
	end
endmodule

//--- src/controlUnit.sv
module controlUnit (
	input cpuPkg::word_t instruction,
	output logic jump,
	output logic branch,
	output logic memToReg,
	output logic memRead,
	output logic memWrite,
	output logic regDst,
	output logic regWrite,
	output logic aluSrc,
	output logic link,
	output logic halt,
	output cpuPkg::aluOp_t aluOp
);
	import cpuPkg::*;

	opcode_t opcode;
	func_t func;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];

	always_comb begin
		// Everything inactive unless the encoding is known
		jump = 1'b0;
		branch = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regDst = 1'b0;
		regWrite = 1'b0;
		aluSrc = 1'b0;
		link = 1'b0;
		halt = 1'b0;
		aluOp = ALU_ZERO;
		case (opcode)
			OP_RTYPE: begin
				case (func)
					FUNC_JPR: jump = 1'b1; // Target from rs
					FUNC_JRL: begin
						jump = 1'b1;
						link = 1'b1;
						regWrite = 1'b1;
					end
					FUNC_HLT: halt = 1'b1;
					FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR,
					FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR: begin
						regDst = 1'b1;
						regWrite = 1'b1;
						case (func)
							FUNC_ADD: aluOp = ALU_ADD;
							FUNC_SUB: aluOp = ALU_SUB;
							FUNC_AND: aluOp = ALU_AND;
							FUNC_ORR: aluOp = ALU_OR;
							FUNC_NOT: aluOp = ALU_NOT;
							FUNC_TCP: aluOp = ALU_TCP;
							FUNC_SHL: aluOp = ALU_ALS;
							default: aluOp = ALU_ARS;
						endcase
					end
					default: ;
				endcase
			end
			OP_ADI, OP_ORI: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
			end
			OP_LHI: regWrite = 1'b1; // Shifted immediate picked in datapath
			OP_LWD: begin
				memToReg = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = ALU_ADD;
			end
			OP_SWD: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = ALU_ADD;
			end
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				branch = 1'b1;
				aluOp = ALU_SUB; // rs against rt
			end
			OP_JMP: begin
				jump = 1'b1;
				aluSrc = 1'b1; // Target from target12
			end
			OP_JAL: begin
				jump = 1'b1;
				aluSrc = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end
endmodule

//--- src/cpuPkg.sv
package cpuPkg;
	localparam int WORD_SIZE = 16;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [1:0] regAddr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [3:0] aluOp_t;

	// Opcodes in instruction[15:12]
	localparam opcode_t OP_BNE = 4'd0;
	localparam opcode_t OP_BEQ = 4'd1;
	localparam opcode_t OP_BGZ = 4'd2;
	localparam opcode_t OP_BLZ = 4'd3;
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_ORI = 4'd5;
	localparam opcode_t OP_LHI = 4'd6;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;
	localparam opcode_t OP_JMP = 4'd9;
	localparam opcode_t OP_JAL = 4'd10;
	localparam opcode_t OP_RTYPE = 4'd15;

	// R-type func field
	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_TCP = 6'd5;
	localparam func_t FUNC_SHL = 6'd6;
	localparam func_t FUNC_SHR = 6'd7;
	localparam func_t FUNC_JPR = 6'd25;
	localparam func_t FUNC_JRL = 6'd26;
	localparam func_t FUNC_HLT = 6'd29;

	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_AND = 4'd2;
	localparam aluOp_t ALU_OR = 4'd3;
	localparam aluOp_t ALU_NOT = 4'd4;
	localparam aluOp_t ALU_TCP = 4'd5;
	localparam aluOp_t ALU_ALS = 4'd6;
	localparam aluOp_t ALU_ARS = 4'd7;
	localparam aluOp_t ALU_ZERO = 4'd8;

	typedef enum logic [1:0] {
		FETCH,
		EXECUTE,
		MEMORY,
		HALTED
	} cpuState_t;
endpackage
